// ==== cam_sync_top.f ====
+incdir+source
source/cam_sync_pkg.sv
source/href_lock.sv
source/raster_timing.sv
source/pixel_line_buffer.sv
source/cam_sync_top.sv
bench/clk_gen.sv
bench/cam_sync_chk.sv
bench/cam_sync_monitor.sv
bench/cam_sync_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the camera sync testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module cam_sync_tb -f cam_sync_top.f -o cam_sync_sim

status=0
./obj_dir/cam_sync_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== bench/cam_sync_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cam_sync_params.svh"

module cam_sync_tb
    import cam_sync_pkg::*;
();

    localparam int FRAME       = `H_TOTAL * `V_TOTAL;
    localparam int PRE_PIX     = 8;  // Pixels written by the short and long lock runs.
    localparam int STREAM_END  = 2 * FRAME + 2 * `H_TOTAL;
    localparam int WATCHDOG_NS = (3 * FRAME + 16 + 300) * 40;

    logic       clk;
    logic       rstn;
    logic       cam_href;
    pixel_t     cam_pixel;
    logic       vsync, hsync, data_en, read_en, locked, underflow;
    xpos_t      x;
    ypos_t      y;
    pixel_t     pixel;
    logic       exp_hsync, exp_vsync, exp_data_en, exp_read_en;
    logic       exp_locked, exp_underflow, finish;
    xpos_t      exp_x;
    ypos_t      exp_y;
    logic [2:0] phase;
    int         error_count;
    logic [31:0] lfsr;

    clk_gen clk_gen_i (.clk(clk), .rstn(rstn));

    cam_sync_top dut_i (
        .clk(clk), .rstn(rstn), .cam_href(cam_href), .cam_pixel(cam_pixel),
        .vsync(vsync), .hsync(hsync), .data_en(data_en), .read_en(read_en),
        .x(x), .y(y), .pixel(pixel), .locked(locked), .underflow(underflow)
    );

    cam_sync_monitor monitor_i (
        .clk(clk), .rstn(rstn), .cam_href(cam_href), .cam_pixel(cam_pixel),
        .hsync(hsync), .vsync(vsync), .data_en(data_en), .read_en(read_en),
        .x(x), .y(y), .pixel(pixel), .locked(locked), .underflow(underflow),
        .exp_hsync(exp_hsync), .exp_vsync(exp_vsync), .exp_data_en(exp_data_en),
        .exp_read_en(exp_read_en), .exp_x(exp_x), .exp_y(exp_y),
        .exp_locked(exp_locked), .exp_underflow(exp_underflow),
        .phase(phase), .finish(finish), .error_count(error_count)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_pixel(output pixel_t p);
        p = '0;
        for (int i = 0; i < `PIX_BITS; i++) begin
            lfsr = lfsr_step(lfsr);
            p = {p[`PIX_BITS-2:0], lfsr[0]};
        end
    endtask

    // Raster position p as {hsync, vsync, data_en, x, y}.
    function automatic logic [11:0] ref_timing(input int p);
        int    h;
        int    v;
        logic  hs;
        logic  vs;
        logic  de;
        xpos_t xv;
        ypos_t yv;
        if (p < 0) begin
            return '0;
        end
        h  = p % `H_TOTAL;
        v  = (p / `H_TOTAL) % `V_TOTAL;
        hs = (h >= `H_ACT + `H_FP) && (h < `H_ACT + `H_FP + `H_SYNC);
        vs = (v >= `V_ACT + `V_FP) && (v < `V_ACT + `V_FP + `V_SYNC);
        de = (h < `H_ACT) && (v < `V_ACT);
        xv = de ? xpos_t'(h) : '0;
        yv = de ? ypos_t'(v) : '0;
        return {hs, vs, de, xv, yv};
    endfunction

    task automatic drive_run(input logic level, input int cycles);
        pixel_t p;
        repeat (cycles) begin
            @(negedge clk);
            cam_href = level;
            if (level) begin
                next_pixel(p);
                cam_pixel = p;
            end else begin
                cam_pixel = '0;
            end
        end
    endtask

    initial begin
        logic [11:0] cur;
        logic [11:0] nxt;
        pixel_t      p;
        cam_href = 1'b0;
        cam_pixel = '0;
        {exp_hsync, exp_vsync, exp_data_en, exp_read_en} = 4'b0;
        exp_x = '0;
        exp_y = '0;
        exp_locked = 1'b0;
        exp_underflow = 1'b0;
        finish = 1'b0;
        phase = 3'd1;
        lfsr = 32'hd804;
        wait (rstn === 1'b1);
        repeat (4) @(negedge clk);
        phase = 3'd2;
        drive_run(1'b1, 4);
        drive_run(1'b0, 4);  // Too short to be a line gap.
        drive_run(1'b1, 4);
        drive_run(1'b0, 1);  // The next edge is the first low sample.
        repeat (`LOCK_THRESH + `LOCK_DELAY) @(negedge clk);
        for (int k = 0; k < STREAM_END; k++) begin
            @(negedge clk);
            exp_locked = 1'b1;
            cur = ref_timing(k - 1);
            nxt = ref_timing(k);
            {exp_hsync, exp_vsync, exp_data_en, exp_x, exp_y} = cur;
            exp_read_en = nxt[9];
            exp_underflow = (k >= 2 * FRAME + PRE_PIX + 1);
            if (k == 1) phase = 3'd3;
            if (k == 2 * FRAME) phase = 3'd4;
            // Camera lines are written in the same cycles the raster reads them.
            if (k < 2 * FRAME && nxt[9]) begin
                next_pixel(p);
                cam_href = 1'b1;
                cam_pixel = p;
            end else begin
                cam_href = 1'b0;
                cam_pixel = '0;
            end
        end
        @(negedge clk);
        finish = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (error_count == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test sequence did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule : cam_sync_tb

`default_nettype wire

// ==== bench/cam_sync_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_sync_monitor
    import cam_sync_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   cam_href,
    input  pixel_t cam_pixel,
    input  logic   hsync,
    input  logic   vsync,
    input  logic   data_en,
    input  logic   read_en,
    input  xpos_t  x,
    input  ypos_t  y,
    input  pixel_t pixel,
    input  logic   locked,
    input  logic   underflow,
    input  logic   exp_hsync,
    input  logic   exp_vsync,
    input  logic   exp_data_en,
    input  logic   exp_read_en,
    input  xpos_t  exp_x,
    input  ypos_t  exp_y,
    input  logic   exp_locked,
    input  logic   exp_underflow,
    input  logic [2:0] phase,
    input  logic   finish,
    output int     error_count
);

    int       err [1:6] = '{default: 0};
    int       tests_failed = 0;
    pixel_t   ref_q [$];
    logic [2:0] prev_phase = 3'd1;
    logic     done = 1'b0;

    initial error_count = 0;

    task automatic check_val(input int test, input string name,
                             input logic [15:0] got, input logic [15:0] expv);
        if (got !== expv) begin
            $display("** Error: %s got %h expected %h at %0t", name, got, expv, $time);
            err[test]++;
            error_count++;
        end
    endtask

    task automatic report(input int test, input string desc);
        if (err[test] == 0) begin
            $display("Test %0d %s: pass", test, desc);
        end else begin
            $display("Test %0d %s: fail with %0d mismatches", test, desc, err[test]);
            tests_failed++;
        end
    endtask

    always @(posedge clk) begin
        pixel_t want;
        if (rstn) begin
            if (phase <= 3'd2) begin
                check_val(2, "locked", 16'(locked), 16'(exp_locked));
                if (!exp_locked) begin
                    check_val(1, "hsync", 16'(hsync), 16'h0);
                    check_val(1, "vsync", 16'(vsync), 16'h0);
                    check_val(1, "data_en", 16'(data_en), 16'h0);
                    check_val(1, "read_en", 16'(read_en), 16'h0);
                    check_val(1, "underflow", 16'(underflow), 16'h0);
                end
            end
            if (phase == 3'd3) begin
                check_val(3, "hsync", 16'(hsync), 16'(exp_hsync));
                check_val(3, "vsync", 16'(vsync), 16'(exp_vsync));
                check_val(3, "data_en", 16'(data_en), 16'(exp_data_en));
                check_val(3, "read_en", 16'(read_en), 16'(exp_read_en));
                // Outside the active area the expected coordinates are zero.
                check_val(4, "x", 16'(x), 16'(exp_x));
                check_val(4, "y", 16'(y), 16'(exp_y));
                check_val(5, "underflow", 16'(underflow), 16'h0);
            end
            if (phase == 3'd4) begin
                check_val(6, "underflow", 16'(underflow), 16'(exp_underflow));
            end
            if (data_en && phase >= 3'd3) begin
                if (ref_q.size() > 0) begin
                    want = ref_q.pop_front();
                    check_val((phase == 3'd3) ? 5 : 6, "pixel", 16'(pixel), 16'(want));
                end else if (phase == 3'd3) begin
                    $display("Error: data_en high but no camera pixel is left at %0t", $time);
                    err[5]++;
                    error_count++;
                end
            end
            if (cam_href) begin
                ref_q.push_back(cam_pixel);  // Every camera write ends up in the buffer.
            end
            if (phase != prev_phase) begin
                if (prev_phase == 3'd2) begin
                    report(1, "outputs idle before lock");
                    report(2, "lock timing");
                end
                if (prev_phase == 3'd3) begin
                    report(3, "sync and enable timing");
                    report(4, "active coordinates");
                    report(5, "pixel order without underflow");
                end
                prev_phase = phase;
            end
            if (finish && !done) begin
                report(6, "underflow after camera stop");
                $display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
                         6 - tests_failed, tests_failed, error_count);
                done = 1'b1;
            end
        end
    end

endmodule : cam_sync_monitor

`default_nettype wire

// ==== bench/cam_sync_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_sync_chk (
    input logic clk,
    input logic rstn,
    input logic read_en,
    input logic data_en,
    input logic hsync,
    input logic vsync,
    input logic locked
);

    int fail_count = 0;

    // A buffer read always shows its pixel on the next cycle.
    read_leads_data: assert property (@(posedge clk) disable iff (!rstn)
        read_en |=> data_en)
        else begin
            fail_count++;
            $error("read_en was not followed by data_en");
        end

    no_de_in_sync: assert property (@(posedge clk) disable iff (!rstn)
        !(data_en && (hsync || vsync)))
        else begin
            fail_count++;
            $error("data_en high during a sync pulse");
        end

    de_needs_lock: assert property (@(posedge clk) disable iff (!rstn)
        data_en |-> locked)
        else begin
            fail_count++;
            $error("data_en high without lock");
        end

endmodule : cam_sync_chk

bind cam_sync_top cam_sync_chk chk_i (
    .clk     (clk),
    .rstn    (rstn),
    .read_en (read_en),
    .data_en (data_en),
    .hsync   (hsync),
    .vsync   (vsync),
    .locked  (locked)
);

`default_nettype wire

// ==== bench/clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period.
    end

    initial begin
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;  // Released away from the rising edge.
    end

endmodule : clk_gen

`default_nettype wire

// ==== source/cam_sync_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_sync_top
    import cam_sync_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   cam_href,
    input  pixel_t cam_pixel,
    output logic   vsync,
    output logic   hsync,
    output logic   data_en,
    output logic   read_en,
    output xpos_t  x,
    output ypos_t  y,
    output pixel_t pixel,
    output logic   locked,
    output logic   underflow
);

    href_lock href_lock_i (
        .clk      (clk),
        .rstn     (rstn),
        .cam_href (cam_href),
        .locked   (locked)
    );

    // The raster runs freely once the camera gap has been found.
    raster_timing raster_timing_i (
        .clk     (clk),
        .rstn    (rstn),
        .locked  (locked),
        .hsync   (hsync),
        .vsync   (vsync),
        .data_en (data_en),
        .read_en (read_en),
        .x       (x),
        .y       (y)
    );

    pixel_line_buffer pixel_line_buffer_i (
        .clk       (clk),
        .rstn      (rstn),
        .cam_href  (cam_href),
        .read_en   (read_en),
        .cam_pixel (cam_pixel),
        .pixel     (pixel),
        .underflow (underflow)
    );

endmodule : cam_sync_top

`default_nettype wire

// ==== source/pixel_line_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cam_sync_params.svh"

module pixel_line_buffer
    import cam_sync_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   cam_href,
    input  logic   read_en,
    input  pixel_t cam_pixel,
    output pixel_t pixel,
    output logic   underflow
);

    pixel_t   mem [`BUF_DEPTH];
    buf_ptr_t wr_ptr;
    buf_ptr_t rd_ptr;
    logic     empty;
    logic     full;
    logic     wr;
    logic     rd;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[`BUF_AW] != rd_ptr[`BUF_AW]) &&
                   (wr_ptr[`BUF_AW-1:0] == rd_ptr[`BUF_AW-1:0]);

    assign wr = cam_href && !full;  // Pixels arriving while full are lost.
    assign rd = read_en && !empty;

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr[`BUF_AW-1:0]] <= cam_pixel;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        pixel <= rd ? mem[rd_ptr[`BUF_AW-1:0]] : '0;
    end

    // Sticky until reset.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            underflow <= 1'b0;
        end else if (read_en && empty) begin
            underflow <= 1'b1;
        end
    end

endmodule : pixel_line_buffer

`default_nettype wire

// ==== source/raster_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cam_sync_params.svh"

module raster_timing
    import cam_sync_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  locked,
    output logic  hsync,
    output logic  vsync,
    output logic  data_en,
    output logic  read_en,
    output xpos_t x,
    output ypos_t y
);

    localparam xpos_t H_ACT_END  = xpos_t'(`H_ACT);
    localparam xpos_t H_SYNC_BEG = xpos_t'(`H_ACT + `H_FP);
    localparam xpos_t H_SYNC_END = xpos_t'(`H_ACT + `H_FP + `H_SYNC);
    localparam xpos_t H_LAST     = xpos_t'(`H_TOTAL - 1);

    localparam ypos_t V_ACT_END  = ypos_t'(`V_ACT);
    localparam ypos_t V_SYNC_BEG = ypos_t'(`V_ACT + `V_FP);
    localparam ypos_t V_SYNC_END = ypos_t'(`V_ACT + `V_FP + `V_SYNC);
    localparam ypos_t V_LAST     = ypos_t'(`V_TOTAL - 1);

    xpos_t h;
    ypos_t v;
    logic  h_act;
    logic  v_act;
    logic  h_sync;
    logic  v_sync;

    // The counters hold the position whose outputs show up on the next cycle.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            h <= '0;
            v <= '0;
        end else if (locked) begin
            if (h == H_LAST) begin
                h <= '0;
                v <= (v == V_LAST) ? '0 : v + 1'b1;
            end else begin
                h <= h + 1'b1;
            end
        end
    end

    assign h_act  = (h < H_ACT_END);
    assign v_act  = (v < V_ACT_END);
    assign h_sync = (h >= H_SYNC_BEG) && (h < H_SYNC_END);
    assign v_sync = (v >= V_SYNC_BEG) && (v < V_SYNC_END);

    // One cycle ahead of the registered data_en below.
    assign read_en = locked && h_act && v_act;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hsync   <= 1'b0;
            vsync   <= 1'b0;
            data_en <= 1'b0;
            x       <= '0;
            y       <= '0;
        end else begin
            hsync   <= locked && h_sync;
            vsync   <= locked && v_sync;
            data_en <= read_en;
            x       <= read_en ? h : '0;  // Coordinates are zero outside the active area.
            y       <= read_en ? v : '0;
        end
    end

endmodule : raster_timing

`default_nettype wire

// ==== source/href_lock.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cam_sync_params.svh"

module href_lock
    import cam_sync_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic cam_href,
    output logic locked
);

    localparam logic [`LOCK_CNT_BITS-1:0] THRESH_LAST = `LOCK_CNT_BITS'(`LOCK_THRESH - 1);
    localparam logic [`LOCK_CNT_BITS-1:0] DELAY_LAST  = `LOCK_CNT_BITS'(`LOCK_DELAY - 1);

    lock_state_t               state;
    logic                      href_d;
    logic                      href_fall;
    logic [`LOCK_CNT_BITS-1:0] cnt;

    assign href_fall = href_d && !cam_href;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            href_d <= 1'b0;
            state  <= LOCK_IDLE;
            cnt    <= '0;
        end else begin
            href_d <= cam_href;
            case (state)
                LOCK_IDLE: begin
                    if (href_fall) begin
                        state <= LOCK_WAIT;
                        cnt   <= '0;
                    end
                end
                LOCK_WAIT: begin
                    if (cam_href) begin
                        state <= LOCK_IDLE;  // Gap too short, start over.
                    end else if (cnt == THRESH_LAST) begin
                        state <= LOCK_DELAY;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                LOCK_DELAY: begin
                    // href is ignored from here on.
                    if (cnt == DELAY_LAST) begin
                        state <= LOCK_DONE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                LOCK_DONE: begin
                    state <= LOCK_DONE;  // Only reset leaves this state.
                end
                default: begin
                    state <= LOCK_IDLE;
                end
            endcase
        end
    end

    assign locked = (state == LOCK_DONE);

endmodule : href_lock

`default_nettype wire

// ==== source/cam_sync_pkg.sv ====
`default_nettype none

`include "cam_sync_params.svh"

package cam_sync_pkg;

    typedef logic [`PIX_BITS-1:0] pixel_t;

    typedef logic [`X_BITS-1:0] xpos_t;
    typedef logic [`Y_BITS-1:0] ypos_t;

    // One bit wider than the address so full and empty differ.
    typedef logic [`BUF_AW:0] buf_ptr_t;

    typedef enum logic [1:0] {
        LOCK_IDLE  = 2'd0,
        LOCK_WAIT  = 2'd1,
        LOCK_DELAY = 2'd2,
        LOCK_DONE  = 2'd3
    } lock_state_t;

endpackage : cam_sync_pkg

`default_nettype wire

// ==== source/cam_sync_params.svh ====
`ifndef CAM_SYNC_PARAMS_SVH
`define CAM_SYNC_PARAMS_SVH

// Horizontal raster, in pixel clocks.
`define H_ACT   16
`define H_FP    4
`define H_SYNC  3
`define H_BP    5
`define H_TOTAL (`H_ACT + `H_FP + `H_SYNC + `H_BP)

// Vertical raster, in lines.
`define V_ACT   6
`define V_FP    2
`define V_SYNC  2
`define V_BP    2
`define V_TOTAL (`V_ACT + `V_FP + `V_SYNC + `V_BP)

`define LOCK_THRESH   8   // Low href cycles that make a line gap.
`define LOCK_DELAY    10  // Cycles from an accepted gap to lock.
`define LOCK_CNT_BITS 4   // Wide enough for both lock counts.

`define PIX_BITS 8

`define BUF_DEPTH 32
`define BUF_AW    5

`define X_BITS 5
`define Y_BITS 4

`endif
